//--- hdl/fdc_pkg.sv
// shared types and constants; geometry fixed at five layouts, image addresses limited to 20 bits
package fdc_pkg;

	// ==================================================
	// types
	// ==================================================
	typedef logic [7:0]  byte_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [2:0]  size_code_t;
	typedef logic [10:0] sec_len_t;   // up to 1024
	typedef logic [19:0] img_addr_t;  // cut to IMG_AW where used
	typedef logic [7:0]  status_t;

	typedef enum logic [2:0] {
		IDLE,
		SETTLE,
		TYPE1_WAIT,
		CHECK,
		XFER_ARM,
		XFER_WAIT,
		XFER_NEXT,
		ENDCMD
	} fdc_state_t;

	// ==================================================
	// host register map
	// ==================================================
	localparam reg_addr_t A_CMD_STATUS = 2'd0;
	localparam reg_addr_t A_TRACK      = 2'd1;
	localparam reg_addr_t A_SECTOR     = 2'd2;
	localparam reg_addr_t A_DATA       = 2'd3;

	// status bit positions; type I and type II share some slots
	localparam int SB_BUSY = 0;
	localparam int SB_DRQ  = 1;  // type II
	localparam int SB_LOST = 2;  // type II
	localparam int SB_TRK0 = 2;  // type I
	localparam int SB_RNF  = 4;
	localparam int SB_WRF  = 5;  // type II
	localparam int SB_HLD  = 5;  // type I
	localparam int SB_WP   = 6;
	localparam int SB_NRDY = 7;

	// delays in clk_sys cycles
	localparam int TYPE1_CYCLES    = 64;
	localparam int SETTLE_CYCLES   = 16;
	localparam int GAP_CYCLES      = 4;
	localparam int WATCHDOG_CYCLES = 4096;

endpackage

//--- hdl/fdc_host_if.sv
// register events and read-back values; event signals are single-cycle pulses
`timescale 1ns/1ps

interface fdc_host_if import fdc_pkg::*; ();

	logic    cmd_wr;       // command register written
	logic    trk_wr;
	logic    sec_wr;
	logic    dat_wr;
	byte_t   wdata;        // valid with any write pulse
	logic    dat_rd_done;  // data read released
	logic    sts_rd_done;  // status read released

	status_t status;
	byte_t   track_reg;
	byte_t   sector_reg;
	byte_t   data_out;

	modport bus (
		output cmd_wr, trk_wr, sec_wr, dat_wr, wdata, dat_rd_done, sts_rd_done,
		input  status, track_reg, sector_reg, data_out
	);

	modport eng (
		input  cmd_wr, trk_wr, sec_wr, dat_wr, wdata, dat_rd_done, sts_rd_done,
		output status, track_reg, sector_reg, data_out
	);

endinterface

//--- hdl/fdc_media_if.sv
// sector addressing and byte path; side comes straight from the top-level pin
`timescale 1ns/1ps

interface fdc_media_if import fdc_pkg::*; ();

	byte_t    head_track;
	logic     side;
	byte_t    sector;
	sec_len_t byte_idx;
	logic     wr_en;     // one-cycle pulse
	byte_t    wr_data;

	sec_len_t sec_len;
	byte_t    spt;       // sectors per track
	logic     sec_ok;
	byte_t    rd_data;   // one cycle behind the address

	modport eng (
		output head_track, sector, byte_idx, wr_en, wr_data,
		input  sec_len, spt, sec_ok, rd_data
	);

	modport map (
		input  head_track, side, sector, byte_idx,
		output sec_len, spt, sec_ok, rd_data
	);

endinterface

//--- hdl/fdc_bus_port.sv
// host bus front end; writes act on strobe rise, data and status reads complete on release
`timescale 1ns/1ps

module fdc_bus_port import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      rd,
	input  logic      wr,
	input  logic      io_en,
	input  reg_addr_t addr,
	input  byte_t     din,
	output byte_t     dout,
	fdc_host_if.bus   host
);

	logic      rde, wre;
	logic      old_rd, old_wr;
	logic      wr_rise, rd_rise, rd_fall;
	reg_addr_t cur_addr;  // address of the open read

	assign rde     = rd & io_en;
	assign wre     = wr & io_en;
	assign wr_rise = wre & ~old_wr;
	assign rd_rise = rde & ~old_rd;
	assign rd_fall = old_rd & ~rde;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			old_rd           <= 1'b0;
			old_wr           <= 1'b0;
			cur_addr         <= A_CMD_STATUS;
			host.cmd_wr      <= 1'b0;
			host.trk_wr      <= 1'b0;
			host.sec_wr      <= 1'b0;
			host.dat_wr      <= 1'b0;
			host.dat_rd_done <= 1'b0;
			host.sts_rd_done <= 1'b0;
		end else begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise)
				cur_addr <= addr;
			host.cmd_wr      <= wr_rise && (addr == A_CMD_STATUS);
			host.trk_wr      <= wr_rise && (addr == A_TRACK);
			host.sec_wr      <= wr_rise && (addr == A_SECTOR);
			host.dat_wr      <= wr_rise && (addr == A_DATA);
			host.dat_rd_done <= rd_fall && (cur_addr == A_DATA);
			host.sts_rd_done <= rd_fall && (cur_addr == A_CMD_STATUS);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise)
			host.wdata <= din;
	end

	always_comb begin
		case (addr)
			A_CMD_STATUS: dout = host.status;
			A_TRACK:      dout = host.track_reg;
			A_SECTOR:     dout = host.sector_reg;
			default:      dout = host.data_out;
		endcase
	end

endmodule

//--- hdl/fdc_cmd_engine.sv
// command FSM; no READ ADDRESS or track commands, Cx/Ex/Fx are ignored, type I index bit reads 0
`timescale 1ns/1ps

module fdc_cmd_engine import fdc_pkg::*; (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     ready,
	input  logic     wp,
	fdc_host_if.eng  host,
	fdc_media_if.eng media,
	output logic     drq,
	output logic     intrq,
	output logic     busy
);

	fdc_state_t  state;
	byte_t       track_reg, sector_reg, data_reg;
	byte_t       head;       // real head position
	byte_t       next_head;
	logic        step_dir;   // 1 = out
	logic        cmd_mode;   // 0 = type I status layout
	logic        is_write, multi;
	logic        f_hld, f_rnf, f_wrf, f_lost;
	logic [7:0]  timer;
	logic [12:0] wdog;
	sec_len_t    byte_idx, rem_cnt;
	logic        wr_en;
	byte_t       wr_data;
	logic        xfer_evt;
	status_t     status_w;

	assign busy      = (state != IDLE);
	assign next_head = (host.wdata[6] ? host.wdata[5] : step_dir) ? head - 8'd1 : head + 8'd1;
	assign xfer_evt  = is_write ? host.dat_wr : host.dat_rd_done;

	// ==================================================
	// state machine and host registers
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			track_reg  <= '0;
			sector_reg <= '0;
			data_reg   <= '0;
			head       <= '0;
			step_dir   <= 1'b0;
			cmd_mode   <= 1'b0;
			is_write   <= 1'b0;
			multi      <= 1'b0;
			{f_hld, f_rnf, f_wrf, f_lost} <= '0;
			timer      <= '0;
			wdog       <= '0;
			byte_idx   <= '0;
			rem_cnt    <= '0;
			wr_en      <= 1'b0;
			drq        <= 1'b0;
			intrq      <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (host.sts_rd_done)
				intrq <= 1'b0;

			case (state)
				TYPE1_WAIT: begin
					if (timer == 0)
						state <= ENDCMD;
					else
						timer <= timer - 8'd1;
				end
				CHECK: begin
					if (!ready) begin
						f_rnf <= 1'b1;
						state <= ENDCMD;
					end else if (is_write && wp) begin
						f_wrf <= 1'b1;
						state <= ENDCMD;
					end else if (!media.sec_ok) begin
						f_rnf <= 1'b1;
						state <= ENDCMD;
					end else begin
						byte_idx <= '0;
						rem_cnt  <= media.sec_len;
						timer    <= 8'(SETTLE_CYCLES);
						state    <= SETTLE;
					end
				end
				SETTLE: begin  // settle or inter-byte gap
					if (timer == 0)
						state <= XFER_ARM;
					else
						timer <= timer - 8'd1;
				end
				XFER_ARM: begin
					drq   <= 1'b1;
					wdog  <= 13'(WATCHDOG_CYCLES);
					state <= XFER_WAIT;
				end
				XFER_WAIT: begin
					if (xfer_evt || wdog == 0) begin
						drq   <= 1'b0;
						state <= XFER_NEXT;
						if (!xfer_evt)
							f_lost <= 1'b1;  // byte dropped
						else if (is_write)
							wr_en <= 1'b1;
						else
							data_reg <= media.rd_data;
					end else begin
						wdog <= wdog - 13'd1;
					end
				end
				XFER_NEXT: begin
					if (rem_cnt == 1) begin
						if (multi) begin
							sector_reg <= sector_reg + 8'd1;
							if (sector_reg >= media.spt) begin  // ran off the track
								f_rnf <= 1'b1;
								state <= ENDCMD;
							end else begin
								state <= CHECK;
							end
						end else begin
							state <= ENDCMD;
						end
					end else begin
						byte_idx <= byte_idx + 11'd1;
						rem_cnt  <= rem_cnt - 11'd1;
						timer    <= 8'(GAP_CYCLES);
						state    <= SETTLE;
					end
				end
				ENDCMD: begin
					drq   <= 1'b0;
					intrq <= 1'b1;
					state <= IDLE;
				end
				default: ;
			endcase

			if (host.cmd_wr) begin
				intrq <= 1'b0;
				if (host.wdata[7:4] == 4'hD) begin  // force interrupt
					cmd_mode <= 1'b0;
					{f_rnf, f_wrf, f_lost} <= '0;
					drq      <= 1'b0;
					state    <= ENDCMD;
				end else if (state == IDLE) begin
					case (host.wdata[7:4])
						4'h0: begin  // restore
							head      <= '0;
							track_reg <= '0;
						end
						4'h1: begin  // seek
							head      <= data_reg;
							track_reg <= data_reg;
						end
						4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
							if (host.wdata[6])
								step_dir <= host.wdata[5];
							head <= next_head;
							if (host.wdata[4])
								track_reg <= next_head;
						end
						4'h8, 4'h9, 4'hA, 4'hB: begin
							cmd_mode <= 1'b1;
							{f_rnf, f_wrf, f_lost} <= '0;
							is_write <= host.wdata[5];
							multi    <= host.wdata[4];
							state    <= CHECK;
						end
						default: ;
					endcase
					if (!host.wdata[7]) begin  // common type I part
						cmd_mode <= 1'b0;
						f_hld    <= host.wdata[3];
						{f_rnf, f_wrf, f_lost} <= '0;
						timer    <= 8'(TYPE1_CYCLES);
						state    <= TYPE1_WAIT;
					end
				end
			end

			if (host.trk_wr && !busy)
				track_reg <= host.wdata;
			if (host.sec_wr && !busy)
				sector_reg <= host.wdata;
			if (host.dat_wr)
				data_reg <= host.wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == XFER_WAIT && host.dat_wr)
			wr_data <= host.wdata;
	end

	// ==================================================
	// status and outputs
	// ==================================================
	always_comb begin
		status_w          = '0;
		status_w[SB_BUSY] = busy;
		status_w[SB_NRDY] = ~ready;
		status_w[SB_WP]   = wp;
		status_w[SB_RNF]  = f_rnf;
		if (cmd_mode) begin
			status_w[SB_WRF]  = f_wrf;
			status_w[SB_LOST] = f_lost;
			status_w[SB_DRQ]  = drq;
		end else begin
			status_w[SB_HLD]  = f_hld;
			status_w[SB_TRK0] = (head == 0);
		end
	end

	assign host.status     = status_w;
	assign host.track_reg  = track_reg;
	assign host.sector_reg = sector_reg;
	assign host.data_out   = (busy && cmd_mode && !is_write) ? media.rd_data : data_reg;

	assign media.head_track = head;
	assign media.sector     = sector_reg;
	assign media.byte_idx   = byte_idx;
	assign media.wr_en      = wr_en;
	assign media.wr_data    = wr_data;

endmodule

//--- hdl/fdc_sector_map.sv
// fixed geometry lookup; codes 5 to 7 act as code 2, addresses past IMG_AW bits wrap
`timescale 1ns/1ps

module fdc_sector_map import fdc_pkg::*; #(
	parameter int IMG_AW = 16
) (
	input  size_code_t  size_code,
	fdc_media_if.map    media,
	output img_addr_t   ram_addr,
	input  byte_t       ram_rdata
);

	img_addr_t ts_idx;    // track * 2 + side
	img_addr_t lin_sec;
	img_addr_t full_addr;

	always_comb begin
		case (size_code)
			3'd0:    begin media.sec_len = 11'd128;  media.spt = 8'd26; end
			3'd1:    begin media.sec_len = 11'd256;  media.spt = 8'd16; end
			3'd3:    begin media.sec_len = 11'd1024; media.spt = 8'd5;  end
			3'd4:    begin media.sec_len = 11'd512;  media.spt = 8'd10; end
			default: begin media.sec_len = 11'd512;  media.spt = 8'd9;  end
		endcase
	end

	assign media.sec_ok = (media.sector != 0) && (media.sector <= media.spt);

	assign ts_idx    = {11'd0, media.head_track, media.side};
	assign lin_sec   = ts_idx * img_addr_t'(media.spt) + img_addr_t'(media.sector) - 20'd1;
	assign full_addr = lin_sec * img_addr_t'(media.sec_len) + img_addr_t'(media.byte_idx);
	assign ram_addr  = img_addr_t'(full_addr[IMG_AW-1:0]);

	assign media.rd_data = ram_rdata;

endmodule

//--- hdl/fdc_image_ram.sv
// dual-port byte RAM of 2**IMG_AW bytes without init; port b wins a same-address write collision
`timescale 1ns/1ps

module fdc_image_ram import fdc_pkg::*; #(
	parameter int IMG_AW = 16
) (
	input  logic      clk_sys,
	input  img_addr_t a_addr,
	input  byte_t     a_wdata,
	input  logic      a_we,
	output byte_t     a_rdata,
	input  img_addr_t b_addr,
	input  byte_t     b_wdata,
	input  logic      b_we,
	output byte_t     b_rdata
);

	byte_t mem [0:(1<<IMG_AW)-1];

	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr[IMG_AW-1:0]] <= a_wdata;
		if (b_we)
			mem[b_addr[IMG_AW-1:0]] <= b_wdata;
	end

	// write-first read ports
	always_ff @(posedge clk_sys) begin
		a_rdata <= a_we ? a_wdata : mem[a_addr[IMG_AW-1:0]];
	end

	always_ff @(posedge clk_sys) begin
		b_rdata <= b_we ? b_wdata : mem[b_addr[IMG_AW-1:0]];
	end

endmodule

//--- hdl/fdc_top.sv
// WD179x-style controller top; the image port may only be used while busy is low
`timescale 1ns/1ps

module fdc_top import fdc_pkg::*; #(
	parameter int IMG_AW = 16
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       rd,
	input  logic       wr,
	input  logic       io_en,
	input  reg_addr_t  addr,
	input  byte_t      din,
	output byte_t      dout,
	output logic       drq,
	output logic       intrq,
	output logic       busy,
	input  logic       ready,
	input  logic       wp,
	input  logic       side,
	input  size_code_t size_code,
	input  img_addr_t  img_addr,
	input  byte_t      img_wdata,
	input  logic       img_we,
	output byte_t      img_rdata
);

	img_addr_t ram_addr;
	byte_t     ram_rdata;

	fdc_host_if  host_if ();
	fdc_media_if media_if ();

	assign media_if.side = side;  // head select pin

	fdc_bus_port u_bus (
		.clk_sys (clk_sys), .arst_n (arst_n), .rd (rd), .wr (wr), .io_en (io_en),
		.addr (addr), .din (din), .dout (dout), .host (host_if.bus)
	);

	fdc_cmd_engine u_eng (
		.clk_sys (clk_sys), .arst_n (arst_n), .ready (ready), .wp (wp),
		.host (host_if.eng), .media (media_if.eng),
		.drq (drq), .intrq (intrq), .busy (busy)
	);

	fdc_sector_map #(.IMG_AW (IMG_AW)) u_map (
		.size_code (size_code), .media (media_if.map),
		.ram_addr (ram_addr), .ram_rdata (ram_rdata)
	);

	// port a is the image port, port b the media path
	fdc_image_ram #(.IMG_AW (IMG_AW)) u_ram (
		.clk_sys (clk_sys),
		.a_addr (img_addr), .a_wdata (img_wdata), .a_we (img_we), .a_rdata (img_rdata),
		.b_addr (ram_addr), .b_wdata (media_if.wr_data), .b_we (media_if.wr_en),
		.b_rdata (ram_rdata)
	);

endmodule

//--- include/fdc_tb_model.svh
// reference model for the testbench; needs fdc_pkg imported by the includer, 64 KiB image only
`ifndef FDC_TB_MODEL_SVH
`define FDC_TB_MODEL_SVH

localparam int MODEL_AW = 16;

byte_t model_img [0:(1<<MODEL_AW)-1];  // mirror of the image RAM

function automatic sec_len_t model_sec_len(input size_code_t sc);
	case (sc)
		3'd0:    return 11'd128;
		3'd1:    return 11'd256;
		3'd3:    return 11'd1024;
		default: return 11'd512;   // codes 2, 4 and unused ones
	endcase
endfunction

function automatic byte_t model_spt(input size_code_t sc);
	case (sc)
		3'd0:    return 8'd26;
		3'd1:    return 8'd16;
		3'd3:    return 8'd5;
		3'd4:    return 8'd10;
		default: return 8'd9;
	endcase
endfunction

function automatic img_addr_t model_addr(input size_code_t sc, input byte_t trk,
		input logic sd, input byte_t sec, input sec_len_t idx);
	img_addr_t ts;
	img_addr_t lin;
	ts  = img_addr_t'({trk, sd});
	lin = ts * img_addr_t'(model_spt(sc)) + img_addr_t'(sec) - 20'd1;
	return (lin * img_addr_t'(model_sec_len(sc)) + img_addr_t'(idx)) % (1 << MODEL_AW);
endfunction

// head position after one step; dir_out set means toward track 0
function automatic byte_t model_step(input byte_t head, input logic dir_out);
	return dir_out ? head - 8'd1 : head + 8'd1;
endfunction

// type II status once the command has ended
function automatic status_t model_end_status(input logic rdy, input logic wprot,
		input logic rnf, input logic wrf, input logic lost);
	status_t st;
	st          = '0;
	st[SB_NRDY] = ~rdy;
	st[SB_WP]   = wprot;
	st[SB_WRF]  = wrf;
	st[SB_RNF]  = rnf;
	st[SB_LOST] = lost;
	return st;
endfunction

`endif

//--- verification/tb_fdc.sv
// random-stimulus testbench; 64 KiB image mirror, tracks kept below 6 so image addresses never wrap
`timescale 1ns/1ps

module tb_fdc import fdc_pkg::*; ();

	`include "fdc_tb_model.svh"

	logic       clk_sys;
	logic       arst_n;
	logic       rd, wr, io_en;
	reg_addr_t  addr;
	byte_t      din, dout;
	logic       drq, intrq, busy;
	logic       ready, wp, side;
	size_code_t size_code;
	img_addr_t  img_addr;
	byte_t      img_wdata, img_rdata;
	logic       img_we;

	int         n_err;
	int         n_tmo;
	byte_t      m_head, m_track;  // model head and track register
	logic       m_dir;            // model step direction where 1 = out

	fdc_top #(.IMG_AW (MODEL_AW)) u_dut (
		.clk_sys (clk_sys), .arst_n (arst_n), .rd (rd), .wr (wr), .io_en (io_en),
		.addr (addr), .din (din), .dout (dout), .drq (drq), .intrq (intrq), .busy (busy),
		.ready (ready), .wp (wp), .side (side), .size_code (size_code),
		.img_addr (img_addr), .img_wdata (img_wdata), .img_we (img_we),
		.img_rdata (img_rdata)
	);

	always #5 clk_sys = ~clk_sys;

	// ==================================================
	// bus and wait helpers
	// ==================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;  // drive point after the edge
	endtask

	task automatic bus_write(input reg_addr_t a, input byte_t d);
		addr  = a;
		din   = d;
		wr    = 1'b1;
		io_en = 1'b1;
		next_cycle();
		wr    = 1'b0;
		io_en = 1'b0;
		next_cycle();  // event pulse
		next_cycle();  // engine has reacted
	endtask

	task automatic bus_read(input reg_addr_t a, output byte_t d);
		addr  = a;
		rd    = 1'b1;
		io_en = 1'b1;
		next_cycle();
		d     = dout;
		rd    = 1'b0;
		io_en = 1'b0;
		next_cycle();
		next_cycle();  // release seen by the engine
	endtask

	task automatic wait_drq(input int limit);
		int n;
		n = 0;
		while (drq !== 1'b1 && n < limit) begin
			next_cycle();
			n++;
		end
		if (drq !== 1'b1) begin
			n_tmo++;
			$display("drq did not rise within %0d cycles", limit);
		end
	endtask

	task automatic wait_drq_low(input int limit);
		int n;
		n = 0;
		while (drq !== 1'b0 && n < limit) begin
			next_cycle();
			n++;
		end
		if (drq !== 1'b0) begin
			n_tmo++;
			$display("drq stayed high for more than %0d cycles", limit);
		end
	endtask

	task automatic wait_intrq(input int limit);
		int n;
		n = 0;
		while (intrq !== 1'b1 && n < limit) begin
			next_cycle();
			n++;
		end
		if (intrq !== 1'b1) begin
			n_tmo++;
			$display("intrq did not rise within %0d cycles", limit);
		end else begin
			check_flag("busy", busy, 1'b0);  // falls with intrq
		end
	endtask

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			n_err++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		if (got !== exp) begin
			n_err++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr_data(input img_addr_t a, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			n_err++;
			$display("FAILED img_rdata at %h: got %h, expected %h", a, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			n_err++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ==================================================
	// command sequences
	// ==================================================
	function automatic status_t type1_status(input logic hld, input byte_t head);
		status_t st;
		st          = '0;
		st[SB_HLD]  = hld;
		st[SB_TRK0] = (head == 8'd0);
		st[SB_WP]   = wp;
		st[SB_NRDY] = ~ready;
		return st;
	endfunction

	task automatic run_type1(input byte_t cmd);
		byte_t st;
		bus_write(A_CMD_STATUS, cmd);
		wait_intrq(TYPE1_CYCLES + 16);
		bus_read(A_CMD_STATUS, st);
		check_status("status", st, type1_status(cmd[3], m_head));
	endtask

	task automatic seek_to(input byte_t trk);
		bus_write(A_DATA, trk);
		m_head  = trk;
		m_track = trk;
		run_type1(8'h10);
	endtask

	task automatic end_command(input status_t exp);
		byte_t st;
		wait_intrq(64);
		check_flag("drq", drq, 1'b0);
		bus_read(A_CMD_STATUS, st);
		check_status("status", st, exp);
	endtask

	task automatic load_image();
		for (int i = 0; i < (1 << MODEL_AW); i++) begin
			img_addr     = img_addr_t'(i);
			img_wdata    = byte_t'($urandom);
			img_we       = 1'b1;
			model_img[i] = img_wdata;
			next_cycle();
		end
		img_we = 1'b0;
	endtask

	task automatic read_bytes(input size_code_t sc, input byte_t trk, input logic sd,
			input byte_t sec, input int first);
		byte_t     d;
		img_addr_t a;
		for (int i = first; i < int'(model_sec_len(sc)); i++) begin
			wait_drq(64);
			bus_read(A_DATA, d);
			a = model_addr(sc, trk, sd, sec, sec_len_t'(i));
			check_byte("dout", d, model_img[a]);
		end
	endtask

	task automatic write_bytes(input size_code_t sc, input byte_t trk, input logic sd,
			input byte_t sec);
		byte_t d;
		for (int i = 0; i < int'(model_sec_len(sc)); i++) begin
			wait_drq(64);
			d = byte_t'($urandom);
			bus_write(A_DATA, d);
			model_img[model_addr(sc, trk, sd, sec, sec_len_t'(i))] = d;
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		byte_t      d, t, cmd, trk, sec, spt, start;
		size_code_t sc;
		logic       sd;
		img_addr_t  a;
		clk_sys   = 1'b0;
		arst_n    = 1'b0;
		{rd, wr, io_en} = 3'b000;
		addr      = A_CMD_STATUS;
		din       = '0;
		ready     = 1'b1;
		wp        = 1'b0;
		side      = 1'b0;
		size_code = '0;
		img_addr  = '0;
		img_wdata = '0;
		img_we    = 1'b0;
		n_err     = 0;
		n_tmo     = 0;
		m_head    = '0;
		m_track   = '0;
		m_dir     = 1'b0;
		void'($urandom(32'h489c));
		repeat (4) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
		next_cycle();

		check_flag("drq", drq, 1'b0);
		check_flag("intrq", intrq, 1'b0);
		check_flag("busy", busy, 1'b0);
		bus_read(A_TRACK, d);
		check_byte("track_reg", d, 8'h00);
		bus_read(A_SECTOR, d);
		check_byte("sector_reg", d, 8'h00);

		// type I commands
		repeat (4) begin
			t = byte_t'($urandom);
			bus_write(A_TRACK, t);
			bus_read(A_TRACK, d);
			check_byte("track_reg", d, t);
		end
		seek_to(byte_t'(1 + $urandom % 255));  // head away from track 0
		m_head  = '0;
		m_track = '0;
		run_type1(byte_t'($urandom) & 8'h0F);  // restore with random hld and rate bits
		bus_read(A_TRACK, d);
		check_byte("track_reg", d, m_track);
		seek_to(byte_t'($urandom));
		bus_read(A_TRACK, d);
		check_byte("track_reg", d, m_track);
		repeat (12) begin
			cmd = byte_t'(8'h20 + $urandom % 96);  // step, step-in, step-out
			if (cmd[6])
				m_dir = cmd[5];
			m_head = model_step(m_head, m_dir);
			if (cmd[4])
				m_track = m_head;
			run_type1(cmd);
			bus_read(A_TRACK, d);
			check_byte("track_reg", d, m_track);
		end

		// single sector reads
		load_image();
		repeat (3) begin
			sc  = size_code_t'($urandom % 8);
			sd  = 1'($urandom % 2);
			trk = byte_t'($urandom % 6);
			spt = model_spt(sc);
			sec = byte_t'(1 + $urandom % spt);
			size_code = sc;
			side      = sd;
			seek_to(trk);
			bus_write(A_SECTOR, sec);
			bus_write(A_CMD_STATUS, 8'h80);
			read_bytes(sc, trk, sd, sec, 0);
			end_command(model_end_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
		end

		// multisector write up to the end of the track
		sc    = size_code_t'($urandom % 5);
		sd    = 1'($urandom % 2);
		trk   = byte_t'($urandom % 6);
		spt   = model_spt(sc);
		start = byte_t'(spt - $urandom % 3);
		size_code = sc;
		side      = sd;
		seek_to(trk);
		bus_write(A_SECTOR, start);
		bus_write(A_CMD_STATUS, 8'hB0);
		for (int s = start; s <= spt; s++)
			write_bytes(sc, trk, sd, byte_t'(s));
		end_command(model_end_status(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		bus_read(A_SECTOR, d);
		check_byte("sector_reg", d, spt + 8'd1);
		for (int s = start; s <= spt; s++) begin
			for (int i = 0; i < int'(model_sec_len(sc)); i++) begin
				a        = model_addr(sc, trk, sd, byte_t'(s), sec_len_t'(i));
				img_addr = a;
				next_cycle();
				check_addr_data(a, img_rdata, model_img[a]);
			end
		end

		// error paths
		size_code = 3'd0;
		side      = 1'b0;
		wp        = 1'b1;
		bus_write(A_SECTOR, 8'd1);
		bus_write(A_CMD_STATUS, 8'hA0);
		end_command(model_end_status(1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
		wp = 1'b0;
		bus_write(A_SECTOR, 8'd0);
		bus_write(A_CMD_STATUS, 8'h80);
		end_command(model_end_status(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		bus_write(A_SECTOR, byte_t'(model_spt(3'd0) + 1 + $urandom % 200));
		bus_write(A_CMD_STATUS, 8'h80);
		end_command(model_end_status(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		ready = 1'b0;
		bus_write(A_SECTOR, 8'd1);
		bus_write(A_CMD_STATUS, 8'h80);
		end_command(model_end_status(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
		ready = 1'b1;

		// lost data with the first byte left unanswered
		sd  = 1'($urandom % 2);
		trk = byte_t'($urandom % 6);
		sec = byte_t'(1 + $urandom % model_spt(3'd0));
		side = sd;
		seek_to(trk);
		bus_write(A_SECTOR, sec);
		bus_write(A_CMD_STATUS, 8'h80);
		wait_drq(64);
		wait_drq_low(WATCHDOG_CYCLES + 16);
		read_bytes(3'd0, trk, sd, sec, 1);
		end_command(model_end_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));

		// force interrupt in the middle of a read
		bus_write(A_SECTOR, 8'd1);
		bus_write(A_CMD_STATUS, 8'h80);
		wait_drq(64);
		bus_write(A_CMD_STATUS, 8'hD0);
		wait_intrq(16);
		check_flag("drq", drq, 1'b0);
		bus_read(A_CMD_STATUS, d);
		check_status("status", d, type1_status(1'b0, m_head));  // type I layout, flags clear
		check_flag("intrq", intrq, 1'b0);  // cleared by the status read

		$display("summary: %0d value mismatches, %0d timeouts", n_err, n_tmo);
		if (n_err == 0 && n_tmo == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- fdc.f
+incdir+include
hdl/fdc_pkg.sv
hdl/fdc_host_if.sv
hdl/fdc_media_if.sv
hdl/fdc_bus_port.sv
hdl/fdc_cmd_engine.sv
hdl/fdc_sector_map.sv
hdl/fdc_image_ram.sv
hdl/fdc_top.sv
verification/tb_fdc.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f fdc.f --top-module tb_fdc -o tb_fdc
./obj_dir/tb_fdc | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
